// ==== hdl/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`default_nettype none

`define DATA_WIDTH    32        // register and pc width
`define BP_INDEX_BITS 6         // btb index bits
`define IMEM_WORDS    64        // instruction memory depth in words

`default_nettype wire

`endif

// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } alu_op_e;

    // same encoding as funct3 of the branch group
    typedef enum logic [2:0] {
        BR_EQ = 3'b000,
        BR_NE = 3'b001,
        BR_LT = 3'b100,
        BR_GE = 3'b101
    } br_cond_e;

    typedef struct packed {
        logic      reg_write;
        alu_op_e   alu_op;
        logic      src_imm;     // operand b from immediate
        logic      is_lui;
        logic      is_branch;
        logic      is_jump;
        br_cond_e  br_cond;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/pipe_pkg.sv ====
`include "core_params.svh"
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    typedef logic [`DATA_WIDTH-1:0] word_t;

    typedef struct packed {
        logic  hit;
        logic  taken;
        word_t target;
    } pred_t;

    typedef struct packed {
        logic        valid;
        word_t       pc;
        logic [31:0] instr;
        pred_t       pred;
    } f_d_t;

    typedef struct packed {
        logic       valid;
        ctrl_t      ctrl;
        word_t      pc;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        word_t      rv1;
        word_t      rv2;
        word_t      imm;
        pred_t      pred;
    } d_e_t;

    typedef struct packed {
        logic       valid;
        logic       reg_write;
        logic [4:0] rd;
        word_t      result;
        word_t      pc;
    } e_w_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        logic  taken;
        logic  is_jump;     // jumps saturate the counter
        word_t target;
    } bp_update_t;

    typedef struct packed {
        word_t      pc;
        logic       reg_write;
        logic [4:0] rd;
        word_t      data;
    } retire_t;

endpackage

`default_nettype wire

// ==== hdl/pipe_reg.sv ====
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     en,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;        // valid bit drops with the rest
        end else if (en) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/branch_predictor.sv ====
`include "core_params.svh"
`default_nettype none

module branch_predictor
    import pipe_pkg::*;
#(
    parameter int INDEX_BITS = `BP_INDEX_BITS
) (
    input  logic       clk,
    input  logic       rst,
    input  word_t      pc,
    output pred_t      pred,
    input  bp_update_t update
);

    localparam int ENTRIES  = 1 << INDEX_BITS;
    localparam int TAG_BITS = `DATA_WIDTH - INDEX_BITS - 2;

    logic                valid  [ENTRIES];
    logic [TAG_BITS-1:0] tag    [ENTRIES];
    word_t               target [ENTRIES];
    logic [1:0]          cnt    [ENTRIES];

    logic [INDEX_BITS-1:0] rd_idx;
    logic [INDEX_BITS-1:0] wr_idx;
    logic [TAG_BITS-1:0]   rd_tag;
    logic [TAG_BITS-1:0]   wr_tag;
    logic [1:0]            cnt_base;
    logic [1:0]            cnt_next;

    assign rd_idx = pc[INDEX_BITS+1:2];
    assign rd_tag = pc[`DATA_WIDTH-1:INDEX_BITS+2];
    assign wr_idx = update.pc[INDEX_BITS+1:2];
    assign wr_tag = update.pc[`DATA_WIDTH-1:INDEX_BITS+2];

    assign pred.hit    = valid[rd_idx] && (tag[rd_idx] == rd_tag);
    assign pred.taken  = pred.hit && cnt[rd_idx][1];
    assign pred.target = target[rd_idx];

    // a new allocation starts again from weakly not taken
    always_comb begin
        cnt_base = (valid[wr_idx] && tag[wr_idx] == wr_tag) ? cnt[wr_idx] : 2'b01;
        if (update.is_jump) begin
            cnt_next = 2'b11;
        end else if (update.taken) begin
            cnt_next = (cnt_base == 2'b11) ? 2'b11 : cnt_base + 2'd1;
        end else begin
            cnt_next = (cnt_base == 2'b00) ? 2'b00 : cnt_base - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid[i] <= 1'b0;
                cnt[i]   <= 2'b01;      // weakly not taken
            end
        end else if (update.valid) begin
            valid[wr_idx] <= 1'b1;
            cnt[wr_idx]   <= cnt_next;
        end
    end

    always_ff @(posedge clk) begin
        if (update.valid) begin
            tag[wr_idx]    <= wr_tag;
            target[wr_idx] <= update.target;
        end
    end

    a_update_aligned: assert property (
        @(posedge clk) disable iff (rst) update.valid |-> update.pc[1:0] == 2'b00
    ) else $error("predictor trained with unaligned pc");

endmodule

`default_nettype wire

// ==== hdl/fetch.sv ====
`include "core_params.svh"
`default_nettype none

module fetch
    import pipe_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          trigger,
    input  logic                          prog_we,
    input  logic [$clog2(`IMEM_WORDS)-1:0] prog_addr,
    input  logic [31:0]                   prog_data,
    input  pred_t                         pred,
    input  logic                          flush,
    input  word_t                         redirect_pc,
    output f_d_t                          f_d,
    output word_t                         pc
);

    localparam int AW = $clog2(`IMEM_WORDS);

    logic        running;
    logic [31:0] imem [`IMEM_WORDS];
    word_t       next_pc;

    // redirect beats prediction, prediction beats sequential
    assign next_pc = flush ? redirect_pc :
                     (pred.hit && pred.taken) ? pred.target : pc + 'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            pc      <= '0;
        end else begin
            if (trigger) begin
                running <= 1'b1;
            end
            if (running) begin
                pc <= next_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    assign f_d.valid = running;
    assign f_d.pc    = pc;
    assign f_d.instr = imem[pc[AW+1:2]];    // word addressed, wraps
    assign f_d.pred  = pred;

    a_prog_idle: assert property (
        @(posedge clk) disable iff (rst) prog_we |-> !running
    ) else $error("program write while the core is running");

endmodule

`default_nettype wire

// ==== hdl/decode.sv ====
`include "core_params.svh"
`default_nettype none

module decode
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  f_d_t  f_d,
    input  e_w_t  wb,
    output d_e_t  d_e,
    output word_t a0
);

    word_t       regs [31:1];
    logic [31:0] instr;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic        legal;
    ctrl_t       ctrl;
    word_t       imm;

    assign instr  = f_d.instr;
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        ctrl  = '0;
        imm   = {{20{instr[31]}}, instr[31:20]};           // I-type
        legal = 1'b1;
        case (instr[6:0])
            OP_REG: begin
                ctrl.reg_write = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.alu_op = ALU_ADD;
                    10'b0100000_000: ctrl.alu_op = ALU_SUB;
                    10'b0000000_111: ctrl.alu_op = ALU_AND;
                    10'b0000000_110: ctrl.alu_op = ALU_OR;
                    10'b0000000_100: ctrl.alu_op = ALU_XOR;
                    10'b0000000_010: ctrl.alu_op = ALU_SLT;
                    10'b0000000_001: ctrl.alu_op = ALU_SLL;
                    10'b0000000_101: ctrl.alu_op = ALU_SRL;
                    default:         legal = 1'b0;
                endcase
            end
            OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_imm   = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = ALU_ADD;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    default: legal = 1'b0;
                endcase
            end
            OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.is_lui    = 1'b1;
                imm            = {instr[31:12], 12'b0};
            end
            OP_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.br_cond   = br_cond_e'(funct3);
                legal          = (funct3 inside {BR_EQ, BR_NE, BR_LT, BR_GE});
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.is_jump   = 1'b1;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: legal = 1'b0;      // unknown opcode becomes a bubble
        endcase
        if (instr[11:7] == 5'd0) begin
            ctrl.reg_write = 1'b0;      // x0 is never written
        end
    end

    function automatic word_t read_reg(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return '0;
        end else if (wb.valid && wb.reg_write && wb.rd == idx) begin
            return wb.result;           // write-through
        end
        return regs[idx];
    endfunction

    always_comb begin
        d_e.valid = f_d.valid && legal;
        d_e.ctrl  = ctrl;
        d_e.pc    = f_d.pc;
        d_e.rs1   = instr[19:15];
        d_e.rs2   = instr[24:20];
        d_e.rd    = instr[11:7];
        d_e.rv1   = read_reg(instr[19:15]);
        d_e.rv2   = read_reg(instr[24:20]);
        d_e.imm   = imm;
        d_e.pred  = f_d.pred;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.reg_write && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.result;
        end
    end

    assign a0 = regs[10];

    a_no_x0_write: assert property (
        @(posedge clk) disable iff (rst) (wb.valid && wb.reg_write) |-> wb.rd != 5'd0
    ) else $error("writeback targets x0");

endmodule

`default_nettype wire

// ==== hdl/execute.sv ====
`default_nettype none

module execute
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  d_e_t       d_e,
    input  logic       fwd_a,
    input  logic       fwd_b,
    input  word_t      w_result,
    output e_w_t       e_w,
    output logic       actual_taken,
    output word_t      actual_target,
    output bp_update_t update
);

    word_t op_a;
    word_t op_b_reg;
    word_t op_b;
    word_t alu_out;
    word_t pc_plus4;
    word_t br_target;
    logic  cond;

    assign op_a     = fwd_a ? w_result : d_e.rv1;
    assign op_b_reg = fwd_b ? w_result : d_e.rv2;
    assign op_b     = d_e.ctrl.src_imm ? d_e.imm : op_b_reg;
    assign pc_plus4  = d_e.pc + 'd4;
    assign br_target = d_e.pc + d_e.imm;

    always_comb begin
        case (d_e.ctrl.alu_op)
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_SLT: alu_out = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLL: alu_out = op_a << op_b[4:0];
            ALU_SRL: alu_out = op_a >> op_b[4:0];
            default: alu_out = op_a + op_b;
        endcase
    end

    always_comb begin
        case (d_e.ctrl.br_cond)
            BR_EQ:   cond = (op_a == op_b_reg);
            BR_NE:   cond = (op_a != op_b_reg);
            BR_LT:   cond = ($signed(op_a) < $signed(op_b_reg));
            default: cond = ($signed(op_a) >= $signed(op_b_reg));
        endcase
    end

    assign actual_taken  = d_e.valid && (d_e.ctrl.is_jump || (d_e.ctrl.is_branch && cond));
    assign actual_target = br_target;

    assign e_w.valid     = d_e.valid;
    assign e_w.reg_write = d_e.valid && d_e.ctrl.reg_write;
    assign e_w.rd        = d_e.rd;
    assign e_w.pc        = d_e.pc;
    assign e_w.result    = d_e.ctrl.is_jump ? pc_plus4 :      // link address
                           d_e.ctrl.is_lui  ? d_e.imm  : alu_out;

    // btb learns the taken target even when the branch falls through
    assign update.valid   = d_e.valid && (d_e.ctrl.is_branch || d_e.ctrl.is_jump);
    assign update.pc      = d_e.pc;
    assign update.taken   = actual_taken;
    assign update.is_jump = d_e.ctrl.is_jump;
    assign update.target  = br_target;

endmodule

`default_nettype wire

// ==== hdl/hazard_unit.sv ====
`default_nettype none

module hazard_unit
    import pipe_pkg::*;
(
    input  d_e_t  d_e,
    input  e_w_t  e_w,
    input  logic  actual_taken,
    input  word_t actual_target,
    output logic  fwd_a,
    output logic  fwd_b,
    output logic  flush,
    output word_t redirect_pc
);

    word_t pc_plus4;
    word_t pred_next;
    word_t actual_next;
    logic  w_writes;

    assign w_writes = e_w.valid && e_w.reg_write && (e_w.rd != 5'd0);
    assign fwd_a    = w_writes && (e_w.rd == d_e.rs1);
    assign fwd_b    = w_writes && (e_w.rd == d_e.rs2);

    assign pc_plus4    = d_e.pc + 'd4;
    assign pred_next   = (d_e.pred.hit && d_e.pred.taken) ? d_e.pred.target : pc_plus4;
    assign actual_next = actual_taken ? actual_target : pc_plus4;

    // only the next pc matters, a taken hit onto pc+4 is still correct
    assign flush       = d_e.valid && (pred_next != actual_next);
    assign redirect_pc = actual_next;

endmodule

`default_nettype wire

// ==== hdl/core_top.sv ====
`include "core_params.svh"
`default_nettype none

module core_top
    import pipe_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          trigger,
    input  logic                          prog_we,
    input  logic [$clog2(`IMEM_WORDS)-1:0] prog_addr,
    input  logic [31:0]                   prog_data,
    output word_t                         a0,
    output logic                          retire_valid,
    output retire_t                       retire
);

    word_t      f_pc;
    pred_t      f_pred;
    f_d_t       f_d_in;
    f_d_t       f_d_q;
    d_e_t       d_e_in;
    d_e_t       d_e_q;
    e_w_t       e_w_in;
    e_w_t       e_w_q;
    bp_update_t bp_update;
    logic       actual_taken;
    word_t      actual_target;
    logic       fwd_a;
    logic       fwd_b;
    logic       flush;
    word_t      redirect_pc;

    branch_predictor #(
        .INDEX_BITS(`BP_INDEX_BITS)
    ) bp (
        .clk(clk),
        .rst(rst),
        .pc(f_pc),
        .pred(f_pred),
        .update(bp_update)
    );

    fetch fetch_stage (
        .clk(clk),
        .rst(rst),
        .trigger(trigger),
        .prog_we(prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .pred(f_pred),
        .flush(flush),
        .redirect_pc(redirect_pc),
        .f_d(f_d_in),
        .pc(f_pc)
    );

    pipe_reg #(.payload_t(f_d_t)) f_d_reg (
        .clk(clk), .rst(rst), .en(1'b1), .flush(flush), .d(f_d_in), .q(f_d_q)
    );

    decode decode_stage (
        .clk(clk),
        .rst(rst),
        .f_d(f_d_q),
        .wb(e_w_q),
        .d_e(d_e_in),
        .a0(a0)
    );

    pipe_reg #(.payload_t(d_e_t)) d_e_reg (
        .clk(clk), .rst(rst), .en(1'b1), .flush(flush), .d(d_e_in), .q(d_e_q)
    );

    execute execute_stage (
        .d_e(d_e_q),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .w_result(e_w_q.result),
        .e_w(e_w_in),
        .actual_taken(actual_taken),
        .actual_target(actual_target),
        .update(bp_update)
    );

    // the resolving instruction itself moves on to W
    pipe_reg #(.payload_t(e_w_t)) e_w_reg (
        .clk(clk), .rst(rst), .en(1'b1), .flush(1'b0), .d(e_w_in), .q(e_w_q)
    );

    hazard_unit h_u (
        .d_e(d_e_q),
        .e_w(e_w_q),
        .actual_taken(actual_taken),
        .actual_target(actual_target),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .flush(flush),
        .redirect_pc(redirect_pc)
    );

    assign retire_valid     = e_w_q.valid;
    assign retire.pc        = e_w_q.pc;
    assign retire.reg_write = e_w_q.reg_write;
    assign retire.rd        = e_w_q.rd;
    assign retire.data      = e_w_q.result;

endmodule

`default_nettype wire

// ==== dv/core_tb.sv ====
`include "core_params.svh"
`default_nettype none

module core_tb
    import pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int AW = $clog2(`IMEM_WORDS);
    localparam logic [31:0] SELF_JUMP = 32'h0000_006f;     // jal x0, 0

    logic          clk = 1'b0;
    logic          rst;
    logic          trigger;
    logic          prog_we;
    logic [AW-1:0] prog_addr;
    logic [31:0]   prog_data;
    word_t         a0;
    logic          retire_valid;
    retire_t       retire;

    logic [31:0] prog [`IMEM_WORDS];
    word_t       model_regs [32];
    retire_t     exp_q [$];
    int          ret_cycle [$];
    int          cycle_count = 0;
    logic [9:0]  r_ops [8] = '{10'h000, 10'h100, 10'h007, 10'h006,
                               10'h004, 10'h002, 10'h001, 10'h005};  // {funct7, funct3}
    logic [2:0]  i_ops [4] = '{3'b000, 3'b111, 3'b110, 3'b100};
    logic [2:0]  b_ops [4] = '{3'b000, 3'b001, 3'b100, 3'b101};

    core_top UUT (
        .clk(clk),
        .rst(rst),
        .trigger(trigger),
        .prog_we(prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .a0(a0),
        .retire_valid(retire_valid),
        .retire(retire)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [31:0] enc_r(input logic [9:0] f73, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        return {f73[9:3], rs2, rs1, f73[2:0], rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // unused words hold an unknown opcode that differs per address
    task automatic fill_memory();
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            prog[i] = {25'(i * 32'h9e37 + 32'h1234), 7'h00};
        end
    endtask

    task automatic build_alu_program();
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        fill_memory();
        for (int i = 0; i < 40; i++) begin
            rd  = 5'($urandom_range(1, 7));     // few registers, dense dependencies
            rs1 = 5'($urandom_range(0, 7));
            rs2 = 5'($urandom_range(0, 7));
            case ($urandom_range(0, 2))
                0: prog[i] = enc_r(r_ops[$urandom_range(0, 7)], rd, rs1, rs2);
                1: prog[i] = enc_i(i_ops[$urandom_range(0, 3)], rd, rs1, 12'($urandom));
                default: prog[i] = {20'($urandom), rd, 7'b0110111};
            endcase
        end
        prog[40] = SELF_JUMP;
    endtask

    task automatic build_branch_program();
        logic [4:0] r1;
        logic [4:0] r2;
        int         span;
        fill_memory();
        for (int i = 0; i < 4; i++) begin
            prog[i] = enc_i(3'b000, 5'(i + 1), 5'd0, 12'($urandom_range(0, 6)) - 12'd3);
        end
        for (int i = 4; i < 40; i++) begin
            r1   = 5'($urandom_range(1, 4));
            r2   = 5'($urandom_range(1, 4));
            span = $urandom_range(1, (40 - i < 4) ? 40 - i : 4);    // never past the end
            case ($urandom_range(0, 3))
                0: prog[i] = enc_i(3'b000, r1, r2, 12'($urandom_range(0, 4)) - 12'd2);
                1: prog[i] = enc_r(10'h100, r1, r1, r2);
                2: prog[i] = enc_b(b_ops[$urandom_range(0, 3)], r1, r2, 13'(span * 4));
                default: prog[i] = enc_jal(5'($urandom_range(0, 1) * 5), 21'(span * 4));
            endcase
        end
        prog[40] = SELF_JUMP;
    endtask

    task automatic build_loop_program();
        fill_memory();
        prog[0] = enc_i(3'b000, 5'd10, 5'd0, 12'd0);
        prog[1] = enc_i(3'b000, 5'd5, 5'd0, 12'd20);
        prog[2] = enc_r(10'h000, 5'd10, 5'd10, 5'd5);     // a0 += x5
        prog[3] = enc_i(3'b000, 5'd5, 5'd5, 12'hfff);
        prog[4] = enc_b(3'b001, 5'd5, 5'd0, 13'h1ff8);    // back to pc 8
        prog[5] = SELF_JUMP;
    endtask

    // instruction-set model, stops after the third pass through the final self-jump
    task automatic run_model();
        word_t       pc;
        word_t       a;
        word_t       b;
        word_t       res;
        word_t       next;
        word_t       imm_i;
        logic [31:0] ins;
        logic        wr;
        logic        take;
        int          jumps_home;
        retire_t     rec;
        pc = '0;
        jumps_home = 0;
        exp_q.delete();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int step = 0; step < 400 && jumps_home < 3; step++) begin
            ins   = prog[pc[AW+1:2]];
            a     = model_regs[ins[19:15]];
            b     = model_regs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            wr    = 1'b1;
            next  = pc + 32'd4;
            res   = '0;
            case (ins[6:0])
                7'b0110011: begin
                    case ({ins[31:25], ins[14:12]})
                        10'h000: res = a + b;
                        10'h100: res = a - b;
                        10'h007: res = a & b;
                        10'h006: res = a | b;
                        10'h004: res = a ^ b;
                        10'h002: res = {31'b0, $signed(a) < $signed(b)};
                        10'h001: res = a << b[4:0];
                        10'h005: res = a >> b[4:0];
                        default: abort_run("model reached an unsupported register op");
                    endcase
                end
                7'b0010011: begin
                    case (ins[14:12])
                        3'b000:  res = a + imm_i;
                        3'b111:  res = a & imm_i;
                        3'b110:  res = a | imm_i;
                        3'b100:  res = a ^ imm_i;
                        default: abort_run("model reached an unsupported immediate op");
                    endcase
                end
                7'b0110111: res = {ins[31:12], 12'b0};
                7'b1100011: begin
                    wr = 1'b0;
                    case (ins[14:12])
                        3'b000:  take = (a == b);
                        3'b001:  take = (a != b);
                        3'b100:  take = $signed(a) < $signed(b);
                        default: take = $signed(a) >= $signed(b);
                    endcase
                    if (take) begin
                        next = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                7'b1101111: begin
                    res  = pc + 32'd4;
                    next = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                default: abort_run("model reached an unsupported opcode");
            endcase
            wr = wr && (ins[11:7] != 5'd0);
            if (wr) begin
                model_regs[ins[11:7]] = res;
            end
            rec.pc        = pc;
            rec.reg_write = wr;
            rec.rd        = ins[11:7];
            rec.data      = res;
            exp_q.push_back(rec);
            if (ins == SELF_JUMP) begin
                jumps_home++;
            end
            pc = next;
        end
        if (jumps_home < 3) begin
            abort_run("model never settled in the final self-jump");
        end
    endtask

    task automatic run_and_compare(input string name);
        int waited;
        ret_cycle.delete();
        @(posedge clk);
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= AW'(i);
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (10) begin
            @(negedge clk);
            check_equal($sformatf("%s idle retire_valid", name), 32'd0, retire_valid);
            check_equal($sformatf("%s idle a0", name), 32'd0, a0);
        end
        @(posedge clk);
        trigger <= 1'b1;
        @(posedge clk);
        trigger <= 1'b0;
        foreach (exp_q[k]) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
                if (waited > 50) begin
                    abort_run($sformatf("%s: core stopped retiring after %0d instructions",
                                        name, k));
                end
            end while (!retire_valid);
            ret_cycle.push_back(cycle_count);
            check_equal($sformatf("%s #%0d pc", name, k), exp_q[k].pc, retire.pc);
            check_equal($sformatf("%s #%0d reg_write", name, k), exp_q[k].reg_write,
                        retire.reg_write);
            if (exp_q[k].reg_write) begin
                check_equal($sformatf("%s #%0d rd", name, k), exp_q[k].rd, retire.rd);
                check_equal($sformatf("%s #%0d data", name, k), exp_q[k].data, retire.data);
            end
        end
    endtask

    initial begin
        int last_br;
        rst       = 1'b1;
        trigger   = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        void'($urandom(72));
        for (int r = 0; r < 2; r++) begin
            build_alu_program();
            run_model();
            run_and_compare($sformatf("alu%0d", r));
        end
        for (int r = 0; r < 3; r++) begin
            build_branch_program();
            run_model();
            run_and_compare($sformatf("branch%0d", r));
        end
        build_loop_program();
        run_model();
        run_and_compare("loop");
        check_equal("loop a0", model_regs[10], a0);
        last_br = -1;
        foreach (exp_q[k]) begin
            if (exp_q[k].pc == 32'd16) begin
                last_br = k;
            end
        end
        // last five iterations are three instructions each, all predicted
        for (int k = last_br - 13; k <= last_br; k++) begin
            check_equal($sformatf("loop gap before #%0d", k), 32'd1,
                        ret_cycle[k] - ret_cycle[k-1]);
        end
        check_equal("loop exit gap", 32'd3, ret_cycle[last_br+1] - ret_cycle[last_br]);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/pipe_reg.sv
hdl/branch_predictor.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/hazard_unit.sv
hdl/core_top.sv
dv/core_tb.sv
